// ==== rtl/ldpc_dec_const_pkg.sv ====
// fixed widths of the check-node sort path
// message, magnitude and column index sizes
package ldpc_dec_const_pkg;

  // ----------------------------------------------------------
  // message widths
  // ----------------------------------------------------------

  // signed variable-node message, two's complement
  localparam int node_w = 8;

  // magnitude keeps the full width so -128 maps to 128
  // and a masked message maps to all ones

  // ----------------------------------------------------------
  // check geometry
  // ----------------------------------------------------------

  // column index inside one check
  localparam int col_w = 5;  // up to 32 messages per check

  // note that the column counter wraps silently past 31
  // so longer checks are not supported

endpackage

// ==== rtl/ldpc_dec_types_pkg.sv ====
// shared types of the check-node sort path
// message words, strobes, decoded message and sort result structs
package ldpc_dec_types_pkg;

  // ----------------------------------------------------------
  // scalar words
  // ----------------------------------------------------------

  typedef logic signed [ldpc_dec_const_pkg::node_w-1:0] node_t;   // signed message
  typedef logic        [ldpc_dec_const_pkg::node_w-1:0] vnode_t;  // magnitude
  typedef logic        [ldpc_dec_const_pkg::col_w-1:0]  col_t;    // column index

  // ----------------------------------------------------------
  // structs
  // ----------------------------------------------------------

  // framing of one check
  typedef struct packed {
    logic sop;  // first message
    logic eop;  // last message
  } strb_t;

  // decode stage output, one per message
  typedef struct packed {
    logic   sop;
    logic   sign;  // 0 for masked
    vnode_t abs;
    col_t   col;   // column inside the check
  } vn_dec_t;

  // running / final state of the two-minimum sort
  typedef struct packed {
    logic   prod_sign;  // xor of all signs
    vnode_t min1;
    vnode_t min2;
    col_t   min1_col;
  } vn_min_t;

endpackage

// ==== rtl/ldpc_dec_vnode_decode.sv ====
// decode stage of the check-node sort
// sign/magnitude split, masking, column counter, end-of-check flag
`timescale 1ns/1ps

module ldpc_dec_vnode_decode (
  input  logic                        iclk,
  input  logic                        ireset,
  input  logic                        clkena,
  input  logic                        val,
  input  ldpc_dec_types_pkg::strb_t   strb,
  input  logic                        vmask,
  input  ldpc_dec_types_pkg::node_t   vnode,
  output logic                        dec_val,
  output ldpc_dec_types_pkg::vn_dec_t dec,
  output logic                        dec_done
);

  localparam int nw = ldpc_dec_const_pkg::node_w;

  logic                       neg;  // sign bit of the message
  ldpc_dec_types_pkg::vnode_t mag;  // two's complement magnitude

  // ----------------------------------------------------------
  // sign / magnitude
  // ----------------------------------------------------------

  assign neg = vnode[nw-1];
  // invert and add one when negative so -128 gives 128
  assign mag = (ldpc_dec_types_pkg::vnode_t'(vnode) ^ {nw{neg}}) + {{(nw-1){1'b0}}, neg};

  // ----------------------------------------------------------
  // control flags
  // ----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      dec_val  <= 1'b0;
      dec_done <= 1'b0;
    end else if (clkena) begin
      dec_val  <= val;
      dec_done <= val & strb.eop;  // last message of the check seen
    end
  end

  // message payload
  always_ff @(posedge iclk) begin
    if (clkena) begin
      dec.sop <= strb.sop;
      if (vmask) begin  // punctured bit
        dec.sign <= 1'b0;
        dec.abs  <= '1;  // largest magnitude, never a minimum
      end else begin
        dec.sign <= neg;
        dec.abs  <= mag;
      end
      // column counter restarts on each check
      if (val) begin
        dec.col <= strb.sop ? '0 : dec.col + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/ldpc_dec_min_sort.sv ====
// execute stage of the check-node sort
// serial two-minimum sort with sign product and done flag
`timescale 1ns/1ps

module ldpc_dec_min_sort (
  input  logic                        iclk,
  input  logic                        ireset,
  input  logic                        clkena,
  input  logic                        dec_val,
  input  ldpc_dec_types_pkg::vn_dec_t dec,
  input  logic                        dec_done,
  output logic                        sort_done,
  output ldpc_dec_types_pkg::vn_min_t sort,
  output ldpc_dec_types_pkg::col_t    sort_num_m1
);

  logic lt_min1;  // new magnitude beats min1
  logic lt_min2;  // new magnitude beats min2

  // ----------------------------------------------------------
  // compare against the running minima
  // ----------------------------------------------------------

  // strict compares keep the earlier column on a tie
  assign lt_min1 = (dec.abs < sort.min1);
  assign lt_min2 = (dec.abs < sort.min2);

  // ----------------------------------------------------------
  // done flag
  // ----------------------------------------------------------

  // one edge behind dec_done to line up with the final sort state
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sort_done <= 1'b0;
    end else if (clkena) begin
      sort_done <= dec_done;
    end
  end

  // ----------------------------------------------------------
  // serial sort
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (clkena && dec_val) begin
      sort_num_m1 <= dec.col;  // last column seen = count - 1
      if (dec.sop) begin
        // first message opens a new check
        sort.prod_sign <= dec.sign;
        sort.min1      <= dec.abs;
        sort.min2      <= '1;
        sort.min1_col  <= dec.col;
      end else begin
        sort.prod_sign <= sort.prod_sign ^ dec.sign;
        if (lt_min1) begin
          // old min1 drops to second place
          sort.min2     <= sort.min1;
          sort.min1     <= dec.abs;
          sort.min1_col <= dec.col;
        end else if (lt_min2) begin
          sort.min2 <= dec.abs;  // only second place changes
        end
      end
    end
  end

  // a following check may load on the same edge
  // that the result stage latches this one

endmodule

// ==== rtl/ldpc_dec_sort_result.sv ====
// result stage of the check-node sort
// min normalization by factor/8, fail flags, output registers
`timescale 1ns/1ps

module ldpc_dec_sort_result #(
  parameter int norm_factor = 7  // 1..7 -> factor/8, 0 -> no scaling
) (
  input  logic                        iclk,
  input  logic                        ireset,
  input  logic                        clkena,
  input  logic                        sort_done,
  input  ldpc_dec_types_pkg::vn_min_t sort,
  input  ldpc_dec_types_pkg::col_t    sort_num_m1,
  output logic                        sort_val,
  output ldpc_dec_types_pkg::vn_min_t sort_rslt,
  output ldpc_dec_types_pkg::col_t    sort_num_m1_out,
  output logic                        decfail,
  output logic                        minfail
);

  localparam int nw = ldpc_dec_const_pkg::node_w;

  // half of the three dropped bits for round half up
  localparam logic [nw+2:0] rnd_half = {{nw{1'b0}}, 3'b100};

  logic min1_leq1;  // unscaled min1 is 0 or 1

  // ----------------------------------------------------------
  // normalization
  // ----------------------------------------------------------

  // x * factor / 8 with shifts and adds in 3 extra bits of headroom
  function automatic ldpc_dec_types_pkg::vnode_t normalize(
    input ldpc_dec_types_pkg::vnode_t dat
  );
    logic [nw+2:0] d;
    logic [nw+2:0] acc;
    d = {3'b000, dat};
    case (norm_factor)
      1:       acc = d + rnd_half;                           // 0.125
      2:       acc = (d << 1) + rnd_half;                    // 0.25
      3:       acc = (d << 1) + d + rnd_half;                // 0.375
      4:       acc = (d << 2) + rnd_half;                    // 0.5
      5:       acc = (d << 2) + d + rnd_half;                // 0.625
      6:       acc = (d << 2) + (d << 1) + rnd_half;         // 0.75
      7:       acc = (d << 3) - d + rnd_half;                // 0.875
      default: acc = d << 3;                                 // pass through
    endcase
    return acc[nw+2:3];
  endfunction

  // ----------------------------------------------------------
  // fail flags
  // ----------------------------------------------------------

  assign min1_leq1 = (sort.min1[nw-1:1] == '0);  // checked before scaling

  // ----------------------------------------------------------
  // output registers
  // ----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sort_val <= 1'b0;
    end else if (clkena) begin
      sort_val <= sort_done;
    end
  end

  // held between results
  always_ff @(posedge iclk) begin
    if (clkena && sort_done) begin
      sort_rslt.prod_sign <= sort.prod_sign;
      sort_rslt.min1      <= normalize(sort.min1);
      sort_rslt.min2      <= normalize(sort.min2);
      sort_rslt.min1_col  <= sort.min1_col;
      sort_num_m1_out     <= sort_num_m1;
      decfail             <= sort.prod_sign;  // odd number of negative signs
      minfail             <= min1_leq1;
    end
  end

endmodule

// ==== rtl/ldpc_dec_sort_engine.sv ====
// top of the check-node sort engine
// decode, serial sort and result stages plus look-ahead taps
`timescale 1ns/1ps

module ldpc_dec_sort_engine #(
  parameter int norm_factor = 7  // eighths or 0 for no scaling
) (
  input  logic                        iclk,
  input  logic                        ireset,
  input  logic                        clkena,  // freezes the whole pipe
  input  logic                        val,
  input  ldpc_dec_types_pkg::strb_t   strb,
  input  logic                        vmask,
  input  ldpc_dec_types_pkg::node_t   vnode,
  output logic                        sort_val,
  output ldpc_dec_types_pkg::vn_min_t sort_rslt,
  output ldpc_dec_types_pkg::col_t    sort_num_m1,
  output logic                        b1_pre_val,     // one edge before sort_val
  output ldpc_dec_types_pkg::col_t    b1_pre_num_m1,
  output logic                        b2_pre_val,     // two edges before sort_val
  output ldpc_dec_types_pkg::col_t    b2_pre_num_m1,
  output logic                        decfail,
  output logic                        minfail
);

  logic                        dec_val;
  ldpc_dec_types_pkg::vn_dec_t dec;
  logic                        dec_done;
  logic                        sort_done;
  ldpc_dec_types_pkg::vn_min_t sort_st;
  ldpc_dec_types_pkg::col_t    sort_col_m1;

  // ----------------------------------------------------------
  // stages
  // ----------------------------------------------------------

  ldpc_dec_vnode_decode u_decode (
    .iclk     (iclk),     .ireset (ireset),   .clkena (clkena),
    .val      (val),      .strb   (strb),     .vmask  (vmask),
    .vnode    (vnode),    .dec_val(dec_val),  .dec    (dec),
    .dec_done (dec_done)
  );

  ldpc_dec_min_sort u_sort (
    .iclk     (iclk),     .ireset   (ireset),    .clkena     (clkena),
    .dec_val  (dec_val),  .dec      (dec),       .dec_done   (dec_done),
    .sort_done(sort_done), .sort    (sort_st),   .sort_num_m1(sort_col_m1)
  );

  ldpc_dec_sort_result #(.norm_factor(norm_factor)) u_result (
    .iclk           (iclk),        .ireset   (ireset),    .clkena     (clkena),
    .sort_done      (sort_done),   .sort     (sort_st),   .sort_num_m1(sort_col_m1),
    .sort_val       (sort_val),    .sort_rslt(sort_rslt), .sort_num_m1_out(sort_num_m1),
    .decfail        (decfail),     .minfail  (minfail)
  );

  // look-ahead taps
  assign b2_pre_val    = dec_done;
  assign b2_pre_num_m1 = dec.col;      // col of the eop message
  assign b1_pre_val    = sort_done;
  assign b1_pre_num_m1 = sort_col_m1;

endmodule

// ==== bench/tb_clock_gen.sv ====
// testbench clock source for the sort engine
// free-running clock, 4 ns period
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real half_period = 2.0  // ns
) (
  output logic iclk
);

  // ----------------------------------------------------------
  // clock
  // ----------------------------------------------------------

  initial begin
    iclk = 1'b0;  // known level at time 0
  end

  always #(half_period) iclk = ~iclk;

endmodule

// ==== bench/tb_sort_engine.sv ====
// testbench of the check-node sort engine
// trace-driven messages, random clock enable, result and look-ahead checks
`timescale 1ns/1ps

module tb_sort_engine;

  logic iclk, ireset, clkena, val, vmask;
  ldpc_dec_types_pkg::strb_t   strb;
  ldpc_dec_types_pkg::node_t   vnode;
  logic                        sort_val, b1_pre_val, b2_pre_val, decfail, minfail;
  ldpc_dec_types_pkg::vn_min_t sort_rslt;
  ldpc_dec_types_pkg::col_t    sort_num_m1, b1_pre_num_m1, b2_pre_num_m1;

  logic       q_sop[$], q_eop[$], q_mask[$];  // messages from the trace
  logic [7:0] q_node[$];
  int e_min1[$], e_min2[$], e_col[$], e_sign[$], e_num[$], e_dfail[$], e_mfail[$];
  int   val_errs, other_errs, rslt_cnt, b1_cnt, b2_cnt, n_exp, idx, cyc;
  int   fd, code, f_sop, f_eop, f_mask;
  int   a1, a2, a3, a4, a5, a6, a7;
  integer seed;
  logic [7:0]       tag, f_node;
  logic [8*128-1:0] line;
  logic b2_d1, b2_d2, b1_d1;  // look-ahead history over enabled edges
  ldpc_dec_types_pkg::col_t b2_n1, b2_n2, b1_n1;

  tb_clock_gen u_clk (.iclk(iclk));

  ldpc_dec_sort_engine #(.norm_factor(7)) u_dut (
    .iclk(iclk), .ireset(ireset), .clkena(clkena), .val(val), .strb(strb),
    .vmask(vmask), .vnode(vnode), .sort_val(sort_val), .sort_rslt(sort_rslt),
    .sort_num_m1(sort_num_m1), .b1_pre_val(b1_pre_val), .b1_pre_num_m1(b1_pre_num_m1),
    .b2_pre_val(b2_pre_val), .b2_pre_num_m1(b2_pre_num_m1),
    .decfail(decfail), .minfail(minfail)
  );

  task automatic report_mismatch(input string name, input int got, input int exp);
    val_errs++;
    $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
  endtask

  // ----------------------------------------------------------
  // result compare on an enabled edge with sort_val
  // ----------------------------------------------------------

  task automatic check_result();
    int m1, m2, c, s, n, df, mf;
    if (e_min1.size() == 0) begin
      other_errs++;
      $display("sort_val pulse at %0t with no expected result left", $time);
    end else begin
      m1 = e_min1.pop_front();
      m2 = e_min2.pop_front();
      c  = e_col.pop_front();
      s  = e_sign.pop_front();
      n  = e_num.pop_front();
      df = e_dfail.pop_front();
      mf = e_mfail.pop_front();
      if (int'(sort_rslt.min1) != m1) report_mismatch("sort_rslt.min1", int'(sort_rslt.min1), m1);
      if (int'(sort_rslt.min2) != m2) report_mismatch("sort_rslt.min2", int'(sort_rslt.min2), m2);
      if (int'(sort_rslt.min1_col) != c)
        report_mismatch("sort_rslt.min1_col", int'(sort_rslt.min1_col), c);
      if (int'(sort_rslt.prod_sign) != s)
        report_mismatch("sort_rslt.prod_sign", int'(sort_rslt.prod_sign), s);
      if (int'(sort_num_m1) != n) report_mismatch("sort_num_m1", int'(sort_num_m1), n);
      if (int'(decfail) != df) report_mismatch("decfail", int'(decfail), df);
      if (int'(minfail) != mf) report_mismatch("minfail", int'(minfail), mf);
      // look-ahead pulses on the two enabled edges before
      if (!b1_d1) begin
        other_errs++;
        $display("b1_pre_val missing one enabled edge before sort_val at %0t", $time);
      end else if (int'(b1_n1) != n) report_mismatch("b1_pre_num_m1", int'(b1_n1), n);
      if (!b2_d2) begin
        other_errs++;
        $display("b2_pre_val missing two enabled edges before sort_val at %0t", $time);
      end else if (int'(b2_n2) != n) report_mismatch("b2_pre_num_m1", int'(b2_n2), n);
      rslt_cnt++;
    end
  endtask

  // sample mid-cycle with clkena already set for the coming edge
  always @(negedge iclk) begin
    if (ireset) begin
      b2_d1 = 1'b0;
      b2_d2 = 1'b0;
      b1_d1 = 1'b0;
    end else if (clkena) begin
      if (sort_val) check_result();
      if (b1_pre_val) b1_cnt++;
      if (b2_pre_val) b2_cnt++;
      b2_d2 = b2_d1;
      b2_n2 = b2_n1;
      b2_d1 = b2_pre_val;
      b2_n1 = b2_pre_num_m1;
      b1_d1 = b1_pre_val;
      b1_n1 = b1_pre_num_m1;
    end
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    ireset = 1'b1;
    clkena = 1'b1;
    val    = 1'b0;
    strb   = '0;
    vmask  = 1'b0;
    vnode  = '0;
    seed   = 44332;
    {val_errs, other_errs, rslt_cnt, b1_cnt, b2_cnt} = '0;
    fd = $fopen("bench/sort_trace.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open the trace file bench/sort_trace.txt");
    end else begin
      code = $fscanf(fd, " %c", tag);
      while (code == 1) begin
        if (tag == "m") begin  // sop eop vmask vnode
          code = $fscanf(fd, "%d %d %d %h", f_sop, f_eop, f_mask, f_node);
          q_sop.push_back(f_sop[0]);
          q_eop.push_back(f_eop[0]);
          q_mask.push_back(f_mask[0]);
          q_node.push_back(f_node);
        end else if (tag == "e") begin
          code = $fscanf(fd, "%d %d %d %d %d %d %d", a1, a2, a3, a4, a5, a6, a7);
          e_min1.push_back(a1);
          e_min2.push_back(a2);
          e_col.push_back(a3);
          e_sign.push_back(a4);
          e_num.push_back(a5);
          e_dfail.push_back(a6);
          e_mfail.push_back(a7);
        end else begin
          code = $fgets(line, fd);  // comment line
        end
        code = $fscanf(fd, " %c", tag);
      end
      $fclose(fd);
    end
    n_exp = e_min1.size();
    repeat (16) @(posedge iclk);
    if (sort_val || b1_pre_val || b2_pre_val) begin
      other_errs++;
      $display("valid outputs not low during reset");
    end
    #1 ireset = 1'b0;
    // feed messages and hold each while clkena is low
    idx = 0;
    cyc = 0;
    while (idx < q_sop.size() && cyc < 2000) begin
      @(posedge iclk);
      if (clkena && val) idx++;  // taken on this edge
      #1;
      clkena = (($random(seed) & 3) != 0);  // about 3 of 4 edges enabled
      val    = (idx < q_sop.size());
      if (val) begin
        strb.sop = q_sop[idx];
        strb.eop = q_eop[idx];
        vmask    = q_mask[idx];
        vnode    = q_node[idx];
      end
      cyc++;
    end
    if (idx < q_sop.size()) begin
      other_errs++;
      $display("timeout while driving messages, %0d of %0d sent", idx, q_sop.size());
    end
    cyc = 0;
    while (rslt_cnt < n_exp && cyc < 200) begin
      @(posedge iclk);
      #1 clkena = (($random(seed) & 3) != 0);
      cyc++;
    end
    if (rslt_cnt < n_exp) begin
      other_errs++;
      $display("timeout waiting for results, %0d of %0d seen", rslt_cnt, n_exp);
    end
    clkena = 1'b1;
    repeat (12) @(posedge iclk);  // enabled idle tail to catch extra pulses
    if (b1_cnt != n_exp || b2_cnt != n_exp) begin
      other_errs++;
      $display("look-ahead pulse count wrong: b1 %0d, b2 %0d, expected %0d",
               b1_cnt, b2_cnt, n_exp);
    end
    $display("summary: %0d of %0d results, %0d value errors, %0d other errors",
             rslt_cnt, n_exp, val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== bench/sort_trace.txt ====
# m sop eop vmask vnode(hex, signed)
# e min1 min2 min1_col prod_sign num_m1 decfail minfail (decimal, scaled by 7/8)
m 1 0 0 0a
m 0 0 0 fd
m 0 0 0 07
m 0 1 0 ec
e 3 6 1 0 3 0 0
m 1 0 0 06
m 0 0 0 fa
m 0 0 0 09
m 0 0 0 fc
m 0 1 0 fc
e 4 4 3 1 4 1 0
m 1 0 1 85
m 0 0 1 12
m 0 1 1 f0
e 223 223 0 0 2 0 0
m 1 1 0 ff
e 1 223 0 1 0 1 1
m 1 0 0 80
m 0 0 1 03
m 0 0 0 00
m 0 1 0 64
e 0 88 2 1 3 1 1
m 1 0 0 32
m 0 0 0 28
m 0 0 0 d3
m 0 0 0 1e
m 0 0 0 dd
m 0 0 0 3c
m 0 0 0 e2
m 0 1 0 7f
e 26 26 3 1 7 1 0
m 1 0 0 02
m 0 1 0 01
e 1 2 1 0 1 0 1
m 1 0 0 c0
m 0 0 0 f4
m 0 0 0 a6
m 0 0 0 fb
m 0 0 0 05
m 0 1 0 81
e 4 4 3 1 5 1 0

// ==== files.f ====
rtl/ldpc_dec_const_pkg.sv
rtl/ldpc_dec_types_pkg.sv
rtl/ldpc_dec_vnode_decode.sv
rtl/ldpc_dec_min_sort.sv
rtl/ldpc_dec_sort_result.sv
rtl/ldpc_dec_sort_engine.sv
bench/tb_clock_gen.sv
bench/tb_sort_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sort engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f \
  --top-module tb_sort_engine -o tb_sort_engine_sim

./obj_dir/tb_sort_engine_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
  echo "simulation run passed"
else
  echo "simulation run failed"
  exit 1
fi
